// ==== rtl/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Data and address width
`define CACHE_WORD_BITS 32

// Data cache geometry, two ways per set
`define DCACHE_SETS 8

// Words per data block, the dcache FSM assumes two
`define DCACHE_BLOCK_WORDS 2

// Instruction cache frames, one word each
`define ICACHE_SETS 16

// Wait cycles per word in the memory model
`define MEM_LATENCY_DEFAULT 2

`endif

// ==== rtl/cache_types_pkg.sv ====
`include "cache_cfg.svh"

package cache_types_pkg;

  localparam int BYTE_BITS = $clog2(`CACHE_WORD_BITS / 8);
  localparam int DC_BLK_BITS = $clog2(`DCACHE_BLOCK_WORDS);
  localparam int DC_OFF_BITS = DC_BLK_BITS + BYTE_BITS;
  localparam int DC_IDX_BITS = $clog2(`DCACHE_SETS);
  localparam int IC_IDX_BITS = $clog2(`ICACHE_SETS);

  typedef logic [`CACHE_WORD_BITS-1:0] word_t;

  // Frame tags keep every bit above the offset so any set count fits
  typedef logic [`CACHE_WORD_BITS-DC_OFF_BITS-1:0] dtag_t;
  typedef logic [`CACHE_WORD_BITS-BYTE_BITS-1:0] itag_t;

  typedef struct packed {
    logic [`CACHE_WORD_BITS-DC_IDX_BITS-DC_OFF_BITS-1:0] tag;
    logic [DC_IDX_BITS-1:0] idx;
    logic [DC_BLK_BITS-1:0] blkoff;
    logic [BYTE_BITS-1:0] bytoff;
  } dcache_addr_t;

  typedef struct packed {
    logic [`CACHE_WORD_BITS-IC_IDX_BITS-BYTE_BITS-1:0] tag;
    logic [IC_IDX_BITS-1:0] idx;
    logic [BYTE_BITS-1:0] bytoff;
  } icache_addr_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    dtag_t tag;
    word_t [`DCACHE_BLOCK_WORDS-1:0] data;
  } dcache_frame_t;

  typedef struct packed {
    logic valid;
    itag_t tag;
    word_t data;
  } icache_frame_t;

endpackage

// ==== rtl/cache_mem_if.sv ====
// One word request channel between a cache and the memory arbiter
interface cache_mem_if
  import cache_types_pkg::*;
();

  // Request side, held until dwait is low
  logic ren;
  logic wen;
  word_t addr;
  word_t store;

  // Response side, load valid in the cycle dwait is low
  word_t load;
  logic dwait;

  modport cache (
    output ren,
    output wen,
    output addr,
    output store,
    input load,
    input dwait
  );

  modport arbiter (
    input ren,
    input wen,
    input addr,
    input store,
    output load,
    output dwait
  );

endinterface

// ==== rtl/icache.sv ====
`include "cache_cfg.svh"

module icache
  import cache_types_pkg::*;
#(
  parameter int NUM_SETS = `ICACHE_SETS
) (
  input logic CLK,
  input logic nRST,
  input logic imem_ren,
  input word_t imem_addr,
  output logic ihit,
  output word_t imem_load,
  cache_mem_if.cache mif
);

  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int TAG_SHIFT = INDEX_BITS + BYTE_BITS;

  typedef enum logic {
    IDLE,
    FETCH
  } state_t;

  state_t state;
  state_t next_state;
  icache_frame_t frames [NUM_SETS];
  icache_addr_t req;
  logic [INDEX_BITS-1:0] idx;
  itag_t tag;
  logic hit;

  // Tag width follows the set count
  assign req = imem_addr;
  assign idx = imem_addr[TAG_SHIFT-1:BYTE_BITS];
  assign tag = itag_t'(imem_addr >> TAG_SHIFT);

  assign hit = frames[idx].valid && (frames[idx].tag == tag);
  assign ihit = (state == IDLE) && imem_ren && hit;
  assign imem_load = frames[idx].data;

  // Word aligned fetch of the address the core holds until ihit
  assign mif.ren = (state == FETCH);
  assign mif.wen = 1'b0;
  assign mif.addr = {req.tag, req.idx, {BYTE_BITS{1'b0}}};
  assign mif.store = '0;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (imem_ren && !hit) begin
          next_state = FETCH;
        end
      end
      FETCH: begin
        if (!mif.dwait) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      frames <= '{default: '0};
    end else begin
      state <= next_state;
      // Fill on the completing word so the request hits next cycle
      if (state == FETCH && !mif.dwait) begin
        frames[idx].valid <= 1'b1;
        frames[idx].tag <= tag;
        frames[idx].data <= mif.load;
      end
    end
  end

  // Fetch word stays on the channel until memory answers
  a_fetch_held: assert property (@(posedge CLK) disable iff (!nRST)
    mif.ren && mif.dwait |=> mif.ren && $stable(mif.addr));

endmodule

// ==== rtl/dcache.sv ====
`include "cache_cfg.svh"

module dcache
  import cache_types_pkg::*;
#(
  parameter int NUM_SETS = `DCACHE_SETS
) (
  input logic CLK,
  input logic nRST,
  input logic dmem_ren,
  input logic dmem_wen,
  input word_t dmem_addr,
  input word_t dmem_store,
  output logic dhit,
  output word_t dmem_load,
  input logic halt,
  output logic flushed,
  cache_mem_if.cache mif
);

  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int TAG_SHIFT = INDEX_BITS + DC_OFF_BITS;
  localparam int CNT_BITS = INDEX_BITS + 2;

  typedef enum logic [3:0] {
    IDLE,
    WB0,
    WB1,
    LOAD0,
    LOAD1,
    FLUSH,
    WRITE0,
    WRITE1,
    DONE
  } state_t;

  state_t state;
  state_t next_state;
  dcache_frame_t [1:0] frames [NUM_SETS];
  logic [NUM_SETS-1:0] lru;
  logic [CNT_BITS-1:0] flush_cnt;

  dcache_addr_t req;
  logic [INDEX_BITS-1:0] idx;
  dtag_t tag;
  logic [1:0] way_hit;
  logic hit_way;
  logic fill_way;
  logic req_any;

  // Flush walk covers all sets of way 0 then way 1
  logic [INDEX_BITS-1:0] fidx;
  logic fway;
  logic flush_end;

  // Any dirty block still held in the array
  logic any_dirty;

  function automatic word_t block_addr(dtag_t t, logic [INDEX_BITS-1:0] i, logic w);
    block_addr = (word_t'(t) << TAG_SHIFT) | (word_t'(i) << DC_OFF_BITS) |
                 (word_t'(w) << BYTE_BITS);
  endfunction

  assign req = dmem_addr;
  assign idx = dmem_addr[TAG_SHIFT-1:DC_OFF_BITS];
  assign tag = dtag_t'(dmem_addr >> TAG_SHIFT);
  assign req_any = dmem_ren || dmem_wen;

  assign fidx = flush_cnt[INDEX_BITS-1:0];
  assign fway = flush_cnt[INDEX_BITS];
  assign flush_end = flush_cnt[INDEX_BITS+1];

  assign way_hit[0] = frames[idx][0].valid && (frames[idx][0].tag == tag);
  assign way_hit[1] = frames[idx][1].valid && (frames[idx][1].tag == tag);
  assign hit_way = way_hit[1];

  assign dhit = (state == IDLE) && req_any && (|way_hit);
  assign dmem_load = frames[idx][hit_way].data[req.blkoff];
  assign flushed = (state == DONE);

  // Fill an invalid way first and otherwise the LRU way
  always_comb begin
    if (!frames[idx][0].valid) begin
      fill_way = 1'b0;
    end else if (!frames[idx][1].valid) begin
      fill_way = 1'b1;
    end else begin
      fill_way = lru[idx];
    end
  end

  always_comb begin
    any_dirty = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      any_dirty = any_dirty || frames[s][0].dirty || frames[s][1].dirty;
    end
  end

  always_comb begin
    next_state = state;
    mif.ren = 1'b0;
    mif.wen = 1'b0;
    mif.addr = '0;
    mif.store = '0;
    case (state)
      IDLE: begin
        if (halt) begin
          next_state = FLUSH;
        end else if (req_any && !(|way_hit)) begin
          next_state = frames[idx][fill_way].dirty ? WB0 : LOAD0;
        end
      end
      WB0, WB1: begin
        mif.wen = 1'b1;
        mif.addr = block_addr(frames[idx][fill_way].tag, idx, state == WB1);
        mif.store = frames[idx][fill_way].data[state == WB1];
        if (!mif.dwait) begin
          next_state = (state == WB0) ? WB1 : LOAD0;
        end
      end
      LOAD0, LOAD1: begin
        mif.ren = 1'b1;
        mif.addr = {req.tag, req.idx, state == LOAD1, {BYTE_BITS{1'b0}}};
        if (!mif.dwait) begin
          next_state = (state == LOAD0) ? LOAD1 : IDLE;
        end
      end
      FLUSH: begin
        if (flush_end) begin
          next_state = DONE;
        end else if (frames[fidx][fway].dirty) begin
          next_state = WRITE0;
        end
      end
      WRITE0, WRITE1: begin
        mif.wen = 1'b1;
        mif.addr = block_addr(frames[fidx][fway].tag, fidx, state == WRITE1);
        mif.store = frames[fidx][fway].data[state == WRITE1];
        if (!mif.dwait) begin
          next_state = (state == WRITE0) ? WRITE1 : FLUSH;
        end
      end
      DONE: next_state = DONE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      lru <= '0;
      flush_cnt <= '0;
      frames <= '{default: '0};
    end else begin
      state <= next_state;
      case (state)
        IDLE: begin
          if (dhit) begin
            lru[idx] <= ~hit_way;
            if (dmem_wen) begin
              frames[idx][hit_way].data[req.blkoff] <= dmem_store;
              frames[idx][hit_way].dirty <= 1'b1;
            end
          end
        end
        WB1: begin
          // Reload then picks this way as the invalid one
          if (!mif.dwait) begin
            frames[idx][fill_way].valid <= 1'b0;
            frames[idx][fill_way].dirty <= 1'b0;
          end
        end
        LOAD0, LOAD1: begin
          if (!mif.dwait) begin
            frames[idx][fill_way].data[state == LOAD1] <= mif.load;
            if (state == LOAD1) begin
              frames[idx][fill_way].valid <= 1'b1;
              frames[idx][fill_way].dirty <= 1'b0;
              frames[idx][fill_way].tag <= tag;
            end
          end
        end
        FLUSH: begin
          if (!flush_end && !frames[fidx][fway].dirty) begin
            flush_cnt <= flush_cnt + 1'b1;
          end
        end
        WRITE1: begin
          if (!mif.dwait) begin
            frames[fidx][fway].valid <= 1'b0;
            frames[fidx][fway].dirty <= 1'b0;
            flush_cnt <= flush_cnt + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  a_core_one_op: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_ren && dmem_wen));

  // Flush leaves no dirty block behind
  a_flushed_clean: assert property (@(posedge CLK) disable iff (!nRST)
    flushed |-> !any_dirty);

  // Waiting word keeps its address until memory answers
  a_addr_held: assert property (@(posedge CLK) disable iff (!nRST)
    (mif.ren || mif.wen) && mif.dwait |=> $stable(mif.addr));

endmodule

// ==== rtl/mem_arbiter.sv ====
module mem_arbiter
  import cache_types_pkg::*;
(
  input logic CLK,
  input logic nRST,
  cache_mem_if.arbiter imif,
  cache_mem_if.arbiter dmif,
  output logic mem_ren,
  output logic mem_wen,
  output word_t mem_addr,
  output word_t mem_store,
  input word_t mem_load,
  input logic mem_wait
);

  logic d_req;
  logic sel_d;
  logic lock;
  logic owner_d;

  assign d_req = dmif.ren || dmif.wen;

  // Data side wins unless a word already in flight pins the owner
  assign sel_d = lock ? owner_d : d_req;

  assign mem_ren = sel_d ? dmif.ren : imif.ren;
  assign mem_wen = sel_d ? dmif.wen : imif.wen;
  assign mem_addr = sel_d ? dmif.addr : imif.addr;
  assign mem_store = sel_d ? dmif.store : imif.store;

  // Only the owner sees wait fall
  assign dmif.load = mem_load;
  assign imif.load = mem_load;
  assign dmif.dwait = sel_d ? mem_wait : 1'b1;
  assign imif.dwait = sel_d ? 1'b1 : mem_wait;

  // Owner held while memory is still counting a word
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lock <= 1'b0;
      owner_d <= 1'b0;
    end else begin
      lock <= (mem_ren || mem_wen) && mem_wait;
      owner_d <= sel_d;
    end
  end

  // Memory port keeps the same word until wait falls
  a_mem_req_held: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_ren || mem_wen) && mem_wait |=>
      (mem_ren || mem_wen) && $stable(mem_addr) && $stable(mem_store));

endmodule

// ==== rtl/memory_subsystem.sv ====
module memory_subsystem
  import cache_types_pkg::*;
(
  input logic CLK,
  input logic nRST,
  // Instruction side
  input logic imem_ren,
  input word_t imem_addr,
  output logic ihit,
  output word_t imem_load,
  // Data side
  input logic dmem_ren,
  input logic dmem_wen,
  input word_t dmem_addr,
  input word_t dmem_store,
  output logic dhit,
  output word_t dmem_load,
  input logic halt,
  output logic flushed,
  // Memory port
  output logic mem_ren,
  output logic mem_wen,
  output word_t mem_addr,
  output word_t mem_store,
  input word_t mem_load,
  input logic mem_wait
);

  cache_mem_if imem_if ();
  cache_mem_if dmem_if ();

  icache u_icache (
    .CLK(CLK),
    .nRST(nRST),
    .imem_ren(imem_ren),
    .imem_addr(imem_addr),
    .ihit(ihit),
    .imem_load(imem_load),
    .mif(imem_if.cache)
  );

  dcache u_dcache (
    .CLK(CLK),
    .nRST(nRST),
    .dmem_ren(dmem_ren),
    .dmem_wen(dmem_wen),
    .dmem_addr(dmem_addr),
    .dmem_store(dmem_store),
    .dhit(dhit),
    .dmem_load(dmem_load),
    .halt(halt),
    .flushed(flushed),
    .mif(dmem_if.cache)
  );

  mem_arbiter u_arbiter (
    .CLK(CLK),
    .nRST(nRST),
    .imif(imem_if.arbiter),
    .dmif(dmem_if.arbiter),
    .mem_ren(mem_ren),
    .mem_wen(mem_wen),
    .mem_addr(mem_addr),
    .mem_store(mem_store),
    .mem_load(mem_load),
    .mem_wait(mem_wait)
  );

endmodule

// ==== bench/tb_mem_model.sv ====
`include "cache_cfg.svh"

module tb_mem_model
  import cache_types_pkg::*;
#(
  parameter int LATENCY = `MEM_LATENCY_DEFAULT,
  parameter int ADDR_WORD_BITS = 11
) (
  input logic CLK,
  input logic nRST,
  input logic mem_ren,
  input logic mem_wen,
  input word_t mem_addr,
  input word_t mem_store,
  output word_t mem_load,
  output logic mem_wait
);

  localparam int NUM_WORDS = 1 << ADDR_WORD_BITS;

  // Image written by the testbench before reset is released
  word_t words [NUM_WORDS];
  int wait_cnt;
  logic busy;
  logic [ADDR_WORD_BITS-1:0] widx;

  assign busy = mem_ren || mem_wen;
  assign widx = mem_addr[ADDR_WORD_BITS+1:2];
  assign mem_load = words[widx];

  // Wait drops once a held request has waited LATENCY cycles
  assign mem_wait = !(busy && wait_cnt >= LATENCY);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= 0;
    end else if (busy && mem_wait) begin
      wait_cnt <= wait_cnt + 1;
    end else begin
      wait_cnt <= 0;
    end
  end

  // Store lands on the completing edge
  always @(posedge CLK) begin
    if (busy && !mem_wait && mem_wen) begin
      words[widx] = mem_store;
    end
  end

endmodule

// ==== bench/tb_memory_subsystem.sv ====
`include "cache_cfg.svh"

module tb_memory_subsystem
  import cache_types_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY = 2;
  localparam int MEM_WORDS = 2048;
  localparam word_t DATA_BASE = 32'h0000_1000;
  localparam int N_RAND = 24;
  localparam int N_STLD = 8;
  localparam int N_MIXED = 12;
  localparam int N_OPS = N_RAND + 2 * N_STLD + 6 + 2 * N_MIXED + 4 * `DCACHE_SETS;
  // Dirty miss queued behind an instruction word, plus a little slack
  localparam int WORST_CYCLES = 6 * (`MEM_LATENCY_DEFAULT + 1) + 4;
  localparam int TIMEOUT = (N_OPS * WORST_CYCLES + 20) * CLK_PERIOD;

  logic CLK;
  logic nRST;
  logic imem_ren;
  word_t imem_addr;
  logic ihit;
  word_t imem_load;
  logic dmem_ren;
  logic dmem_wen;
  word_t dmem_addr;
  word_t dmem_store;
  logic dhit;
  word_t dmem_load;
  logic halt;
  logic flushed;
  logic mem_ren;
  logic mem_wen;
  word_t mem_addr;
  word_t mem_store;
  word_t mem_load;
  logic mem_wait;

  logic [31:0] lfsr_state;
  word_t ref_data [word_t];
  int errors;
  int checks;

  memory_subsystem UUT (.*);

  tb_mem_model #(.ADDR_WORD_BITS(11)) u_mem (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Initial memory word, every address bit matters
  function automatic word_t mem_image(word_t addr);
    mem_image = ((addr >> 2) * 32'h9E37_79B1) ^ (addr << 13) ^ 32'hC0DE_0000;
  endfunction

  function automatic word_t expected_load(word_t addr);
    if (ref_data.exists(addr)) begin
      expected_load = ref_data[addr];
    end else begin
      expected_load = mem_image(addr);
    end
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic word_t take_bits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    take_bits = v;
  endfunction

  function automatic word_t rand_data_addr();
    rand_data_addr = DATA_BASE | (take_bits(10) << 2);
  endfunction

  function automatic word_t rand_inst_addr();
    rand_inst_addr = take_bits(10) << 2;
  endfunction

  task automatic compare_word(string what, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Called just after a rising edge, returns just after the completing one
  task automatic data_op(logic write, word_t addr, word_t data);
    dmem_ren = !write;
    dmem_wen = write;
    dmem_addr = addr;
    dmem_store = data;
    @(negedge CLK);
    while (!dhit) @(negedge CLK);
    @(posedge CLK);
    #DRIVE_DLY;
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
  endtask

  task automatic fetch_op(word_t addr);
    imem_ren = 1'b1;
    imem_addr = addr;
    @(negedge CLK);
    while (!ihit) @(negedge CLK);
    @(posedge CLK);
    #DRIVE_DLY;
    imem_ren = 1'b0;
  endtask

  // Completed core words, checked mid cycle
  always @(negedge CLK) begin
    if (nRST && dhit && dmem_ren) begin
      compare_word($sformatf("data load %h", dmem_addr), dmem_load, expected_load(dmem_addr));
    end
    if (nRST && dhit && dmem_wen) begin
      ref_data[dmem_addr] = dmem_store;
    end
    if (nRST && ihit && imem_ren) begin
      compare_word($sformatf("fetch %h", imem_addr), imem_load, mem_image(imem_addr));
    end
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout after %0d time units, a request never completed (%0d checks, %0d errors)",
             TIMEOUT, checks, errors);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    word_t a;
    word_t set_addr [3];
    word_t iaddr [N_MIXED];
    word_t daddr [N_MIXED];
    nRST = 1'b0;
    imem_ren = 1'b0;
    imem_addr = '0;
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
    dmem_addr = '0;
    dmem_store = '0;
    halt = 1'b0;
    lfsr_state = 32'd88900;
    errors = 0;
    checks = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      u_mem.words[i[10:0]] = mem_image(word_t'(i) << 2);
    end
    repeat (3) @(posedge CLK);
    #DRIVE_DLY;
    nRST = 1'b1;

    // Quiet outputs out of reset
    @(negedge CLK);
    compare_word("ihit dhit flushed mem_ren mem_wen after reset",
                 word_t'({ihit, dhit, flushed, mem_ren, mem_wen}), '0);
    @(posedge CLK);
    #DRIVE_DLY;

    for (int i = 0; i < N_RAND; i++) begin
      data_op(1'b0, rand_data_addr(), '0);
    end

    for (int i = 0; i < N_STLD; i++) begin
      a = rand_data_addr();
      data_op(1'b1, a, take_bits(32));
      data_op(1'b0, a, '0);
    end

    // Set 5 with three tags, the last one in the second word
    set_addr[0] = DATA_BASE | 32'h0000_0028;
    set_addr[1] = set_addr[0] + 32'h0000_0200;
    set_addr[2] = set_addr[0] + 32'h0000_0404;
    foreach (set_addr[k]) data_op(1'b1, set_addr[k], take_bits(32));
    foreach (set_addr[k]) data_op(1'b0, set_addr[k], '0);

    // Fetches racing data misses on the shared port
    for (int i = 0; i < N_MIXED; i++) begin
      iaddr[i] = rand_inst_addr();
      daddr[i] = rand_data_addr();
    end
    fork
      for (int i = 0; i < N_MIXED; i++) fetch_op(iaddr[i]);
      for (int i = 0; i < N_MIXED; i++) data_op(1'b0, daddr[i], '0);
    join

    halt = 1'b1;
    @(negedge CLK);
    while (!flushed) @(negedge CLK);
    foreach (ref_data[addr]) begin
      compare_word($sformatf("memory %h after flush", addr), u_mem.words[addr[12:2]],
                   ref_data[addr]);
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/cache_types_pkg.sv
rtl/cache_mem_if.sv
rtl/icache.sv
rtl/dcache.sv
rtl/mem_arbiter.sv
rtl/memory_subsystem.sv
bench/tb_mem_model.sv
bench/tb_memory_subsystem.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_memory_subsystem
FILE_LIST = src.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "Testbench failed" $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
